//--- verilog/video_pkg.sv
// shared constants for the sensor front end
// pattern select codes, register map and counter widths
`default_nettype none

package video_pkg;

	// --------------------------------------------------
	// test pattern select codes
	// --------------------------------------------------
	// live sensor data, no pattern
	localparam logic [2:0] PAT_REAL  = 3'b000;
	// one grey level per frame, steps each frame
	localparam logic [2:0] PAT_GRAY  = 3'b001;
	// diagonal ramp, same in every frame
	localparam logic [2:0] PAT_SLANT = 3'b110;
	// diagonal ramp shifted by one each frame
	localparam logic [2:0] PAT_MOVE  = 3'b010;

	// --------------------------------------------------
	// register map, word addresses
	// --------------------------------------------------
	// pattern select, read/write
	localparam logic [1:0] REG_PATTERN = 2'd0;
	// measured lines per frame, read only
	localparam logic [1:0] REG_LINES   = 2'd1;
	// measured pixels per line, read only
	localparam logic [1:0] REG_PIXELS  = 2'd2;
	// completed frames since reset, read only
	localparam logic [1:0] REG_FRAMES  = 2'd3;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	// geometry counters
	localparam int GEOM_W = 16;
	// wishbone data bus
	localparam int WB_DW  = 32;

endpackage

`default_nettype wire

//--- verilog/pattern_regs.sv
// wishbone classic slave for the front end control and status
// one writable pattern select, three read-only geometry registers
`timescale 1ns/1ps
`default_nettype none

module pattern_regs (
	input  wire                            clk,
	input  wire                            i_reset,
	// wishbone classic slave
	input  wire                            i_wb_cyc,
	input  wire                            i_wb_stb,
	input  wire                            i_wb_we,
	input  wire [1:0]                      i_wb_adr,
	input  wire [video_pkg::WB_DW-1:0]     i_wb_dat,
	output logic [video_pkg::WB_DW-1:0]    o_wb_dat,
	output logic                           o_wb_ack,
	// measurements from the geometry monitor
	input  wire [video_pkg::GEOM_W-1:0]    i_lines,
	input  wire [video_pkg::GEOM_W-1:0]    i_pixels,
	input  wire [video_pkg::GEOM_W-1:0]    i_frames,
	// to the pattern inserter
	output logic [2:0]                     o_pattern_sel
);

	// request accepted this cycle
	logic                          wb_req;
	// read mux ahead of the data register
	logic [video_pkg::WB_DW-1:0]   rd_mux;

	// --------------------------------------------------
	// bus handshake
	// --------------------------------------------------
	// no new request right after our own ack
	// the master still holds stb in that cycle
	assign wb_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;

	// single cycle ack, one clock after the request
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_wb_ack <= 1'b0;
		end else begin
			o_wb_ack <= wb_req;
		end
	end

	// --------------------------------------------------
	// write side
	// --------------------------------------------------
	// only the pattern select is writable
	// any code is stored, the inserter decides what it means
	// writes to the status words fall through and are dropped
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_pattern_sel <= video_pkg::PAT_REAL;
		end else if (wb_req && i_wb_we && i_wb_adr == video_pkg::REG_PATTERN) begin
			o_pattern_sel <= i_wb_dat[2:0];
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	// zero extend every field to the bus width
	always_comb begin
		rd_mux = '0;
		case (i_wb_adr)
			video_pkg::REG_PATTERN: begin
				rd_mux[2:0] = o_pattern_sel;
			end
			video_pkg::REG_LINES: begin
				rd_mux[video_pkg::GEOM_W-1:0] = i_lines;
			end
			video_pkg::REG_PIXELS: begin
				rd_mux[video_pkg::GEOM_W-1:0] = i_pixels;
			end
			video_pkg::REG_FRAMES: begin
				rd_mux[video_pkg::GEOM_W-1:0] = i_frames;
			end
			default: begin
				rd_mux = '0;
			end
		endcase
	end

	// data captured on the same edge that raises ack
	// only meaningful while ack is high
	always_ff @(posedge clk) begin
		if (wb_req) begin
			o_wb_dat <= rd_mux;
		end
	end

endmodule

`default_nettype wire

//--- verilog/test_pattern.sv
// test pattern inserter for a parallel sensor stream
// passes pixels through or replaces them with a grey or ramp pattern
// sync and data leave exactly one clock after they arrive
`timescale 1ns/1ps
`default_nettype none

module test_pattern #(
	parameter int SENSOR_DAT_WIDTH = 10
) (
	input  wire                           clk,
	input  wire                           i_reset,
	// sensor stream in
	input  wire                           i_fval,
	input  wire                           i_lval,
	input  wire [SENSOR_DAT_WIDTH-1:0]    i_pix_data,
	// pattern select from the register block
	input  wire [2:0]                     i_pattern_sel,
	// stream out, one clock later
	output logic                          o_fval,
	output logic                          o_lval,
	output logic [SENSOR_DAT_WIDTH-1:0]   o_pix_data
);

	// delayed syncs, these are also the outputs
	logic                           fval_dly;
	logic                           lval_dly;
	logic                           fval_fall;
	logic                           lval_fall;
	// pattern counters
	logic [7:0]                     frame_cnt;
	logic [7:0]                     line_cnt;
	logic [7:0]                     col_cnt;
	// decoded select
	logic                           pat_mode;
	// pattern value in the top byte, zeros below
	logic [SENSOR_DAT_WIDTH-1:0]    pat_word;
	logic [SENSOR_DAT_WIDTH-1:0]    pix_data_reg;

	// --------------------------------------------------
	// sync delay and edges
	// --------------------------------------------------
	// lval only counts inside the frame
	always_ff @(posedge clk) begin
		if (i_reset) begin
			fval_dly <= 1'b0;
			lval_dly <= 1'b0;
		end else begin
			fval_dly <= i_fval;
			lval_dly <= i_fval & i_lval;
		end
	end

	assign fval_fall = fval_dly & ~i_fval;
	assign lval_fall = lval_dly & ~i_lval;

	// --------------------------------------------------
	// pattern counters
	// --------------------------------------------------
	// frame offset, only moves in the moving ramp
	always_ff @(posedge clk) begin
		if (i_reset) begin
			frame_cnt <= '0;
		end else if (i_pattern_sel == video_pkg::PAT_MOVE) begin
			if (fval_fall) begin
				frame_cnt <= frame_cnt + 8'd1;
			end
		end else begin
			frame_cnt <= '0;
		end
	end

	// line start value
	// reload from the frame offset during vertical blanking
	always_ff @(posedge clk) begin
		if (i_reset) begin
			line_cnt <= '0;
		end else begin
			case (i_pattern_sel)
				video_pkg::PAT_SLANT, video_pkg::PAT_MOVE: begin
					if (!i_fval) begin
						line_cnt <= frame_cnt;
					end else if (lval_fall) begin
						line_cnt <= line_cnt + 8'd1;
					end
				end
				default: begin
					line_cnt <= frame_cnt;
				end
			endcase
		end
	end

	// column value, the one that ends up on the pixel
	// grey: one step per frame
	// ramps: one step per active pixel, reload between lines
	always_ff @(posedge clk) begin
		if (i_reset) begin
			col_cnt <= '0;
		end else begin
			case (i_pattern_sel)
				video_pkg::PAT_GRAY: begin
					if (fval_fall) begin
						col_cnt <= col_cnt + 8'd1;
					end
				end
				video_pkg::PAT_SLANT, video_pkg::PAT_MOVE: begin
					if (i_fval && i_lval) begin
						col_cnt <= col_cnt + 8'd1;
					end else begin
						col_cnt <= line_cnt;
					end
				end
				default: begin
					col_cnt <= line_cnt;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// pixel output
	// --------------------------------------------------
	// unknown codes behave as passthrough
	always_comb begin
		case (i_pattern_sel)
			video_pkg::PAT_GRAY, video_pkg::PAT_SLANT, video_pkg::PAT_MOVE: pat_mode = 1'b1;
			default: pat_mode = 1'b0;
		endcase
	end

	// top 8 bits carry the pattern, works from 8 bits up
	always_comb begin
		pat_word = '0;
		pat_word[SENSOR_DAT_WIDTH-1 -: 8] = col_cnt;
	end

	// blanking always outputs zero
	always_ff @(posedge clk) begin
		if (i_reset) begin
			pix_data_reg <= '0;
		end else if (i_fval && i_lval) begin
			pix_data_reg <= pat_mode ? pat_word : i_pix_data;
		end else begin
			pix_data_reg <= '0;
		end
	end

	assign o_fval     = fval_dly;
	assign o_lval     = lval_dly;
	assign o_pix_data = pix_data_reg;

endmodule

`default_nettype wire

//--- verilog/frame_geometry.sv
// frame geometry monitor on the output stream
// measures lines per frame, pixels per line and completed frames
// results are held stable between frame ends for software readback
`timescale 1ns/1ps
`default_nettype none

module frame_geometry (
	input  wire                            clk,
	input  wire                            i_reset,
	// monitored stream
	input  wire                            i_fval,
	input  wire                            i_lval,
	// latched measurements
	output logic [video_pkg::GEOM_W-1:0]   o_lines,
	output logic [video_pkg::GEOM_W-1:0]   o_pixels,
	output logic [video_pkg::GEOM_W-1:0]   o_frames
);

	// previous sync levels
	logic                           fval_d;
	logic                           act_d;
	// current cycle carries a pixel
	logic                           act;
	logic                           line_fall;
	logic                           frame_fall;
	// running counts inside the frame
	logic [video_pkg::GEOM_W-1:0]   pix_cnt;
	logic [video_pkg::GEOM_W-1:0]   line_cnt;
	logic [video_pkg::GEOM_W-1:0]   last_len;

	assign act        = i_fval & i_lval;
	assign line_fall  = act_d & ~act;
	assign frame_fall = fval_d & ~i_fval;

	// --------------------------------------------------
	// edge detect
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			fval_d <= 1'b0;
			act_d  <= 1'b0;
		end else begin
			fval_d <= i_fval;
			act_d  <= act;
		end
	end

	// --------------------------------------------------
	// per line and per frame counting
	// --------------------------------------------------
	// pixel count clears in blanking after the line length is saved
	always_ff @(posedge clk) begin
		if (i_reset) begin
			pix_cnt  <= '0;
			last_len <= '0;
		end else if (act) begin
			pix_cnt <= pix_cnt + 1'b1;
		end else begin
			if (line_fall) begin
				last_len <= pix_cnt;
			end
			pix_cnt <= '0;
		end
	end

	// lines seen so far in this frame
	always_ff @(posedge clk) begin
		if (i_reset) begin
			line_cnt <= '0;
		end else if (frame_fall) begin
			line_cnt <= '0;
		end else if (line_fall) begin
			line_cnt <= line_cnt + 1'b1;
		end
	end

	// --------------------------------------------------
	// latch at frame end
	// --------------------------------------------------
	// a line ending on the same cycle as the frame still counts
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_lines  <= '0;
			o_pixels <= '0;
			o_frames <= '0;
		end else if (frame_fall) begin
			o_lines  <= line_fall ? line_cnt + 1'b1 : line_cnt;
			o_pixels <= line_fall ? pix_cnt : last_len;
			o_frames <= o_frames + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/sensor_frontend_top.sv
// camera sensor front end, top level
// register block, test pattern inserter and geometry monitor on one clock
`timescale 1ns/1ps
`default_nettype none

module sensor_frontend_top #(
	parameter int SENSOR_DAT_WIDTH = 10
) (
	input  wire                            clk,
	input  wire                            i_reset,
	// wishbone classic slave
	input  wire                            i_wb_cyc,
	input  wire                            i_wb_stb,
	input  wire                            i_wb_we,
	input  wire [1:0]                      i_wb_adr,
	input  wire [video_pkg::WB_DW-1:0]     i_wb_dat,
	output wire [video_pkg::WB_DW-1:0]     o_wb_dat,
	output wire                            o_wb_ack,
	// sensor stream in
	input  wire                            i_fval,
	input  wire                            i_lval,
	input  wire [SENSOR_DAT_WIDTH-1:0]     i_pix_data,
	// stream to the image pipeline
	output wire                            o_fval,
	output wire                            o_lval,
	output wire [SENSOR_DAT_WIDTH-1:0]     o_pix_data
);

	// pattern select, registers to inserter
	wire [2:0]                      pattern_sel;
	// measurements, monitor to registers
	wire [video_pkg::GEOM_W-1:0]    geom_lines;
	wire [video_pkg::GEOM_W-1:0]    geom_pixels;
	wire [video_pkg::GEOM_W-1:0]    geom_frames;

	// --------------------------------------------------
	// control and status
	// --------------------------------------------------
	pattern_regs u_regs (
		.clk           (clk),
		.i_reset       (i_reset),
		.i_wb_cyc      (i_wb_cyc),
		.i_wb_stb      (i_wb_stb),
		.i_wb_we       (i_wb_we),
		.i_wb_adr      (i_wb_adr),
		.i_wb_dat      (i_wb_dat),
		.o_wb_dat      (o_wb_dat),
		.o_wb_ack      (o_wb_ack),
		.i_lines       (geom_lines),
		.i_pixels      (geom_pixels),
		.i_frames      (geom_frames),
		.o_pattern_sel (pattern_sel)
	);

	// --------------------------------------------------
	// data path
	// --------------------------------------------------
	test_pattern #(
		.SENSOR_DAT_WIDTH (SENSOR_DAT_WIDTH)
	) u_pattern (
		.clk           (clk),
		.i_reset       (i_reset),
		.i_fval        (i_fval),
		.i_lval        (i_lval),
		.i_pix_data    (i_pix_data),
		.i_pattern_sel (pattern_sel),
		.o_fval        (o_fval),
		.o_lval        (o_lval),
		.o_pix_data    (o_pix_data)
	);

	// monitor watches what actually leaves the block
	frame_geometry u_geom (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_fval   (o_fval),
		.i_lval   (o_lval),
		.o_lines  (geom_lines),
		.o_pixels (geom_pixels),
		.o_frames (geom_frames)
	);

endmodule

`default_nettype wire

//--- dv/sensor_frontend_sva.sv
// concurrent checks on the front end top level, attached with bind
// sync delay, zero pixels in blanking and the single-cycle wishbone ack
`timescale 1ns/1ps
`default_nettype none

module sensor_frontend_sva #(
	parameter int DAT_W = 10
) (
	input wire              clk,
	input wire              i_reset,
	input wire              i_fval,
	input wire              i_lval,
	input wire              o_fval,
	input wire              o_lval,
	input wire [DAT_W-1:0]  o_pix_data,
	input wire              o_wb_ack
);

	// failed assertions so far
	int unsigned fail_cnt = 0;

	// --------------------------------------------------
	// stream timing
	// --------------------------------------------------
	// syncs leave exactly one clock after they arrive
	fval_delay: assert property (@(posedge clk) disable iff (i_reset)
		o_fval == $past(i_fval))
		else begin
			$error("fval output differs from the input one clock earlier");
			fail_cnt++;
		end

	// lval is gated by fval on the way through
	lval_delay: assert property (@(posedge clk) disable iff (i_reset)
		o_lval == $past(i_fval & i_lval))
		else begin
			$error("lval output differs from the gated input one clock earlier");
			fail_cnt++;
		end

	// blanking carries no pixel data
	blank_zero: assert property (@(posedge clk) disable iff (i_reset)
		!(o_fval && o_lval) |-> o_pix_data == '0)
		else begin
			$error("pixel output nonzero outside active pixels");
			fail_cnt++;
		end

	// --------------------------------------------------
	// bus handshake
	// --------------------------------------------------
	ack_single: assert property (@(posedge clk) disable iff (i_reset)
		o_wb_ack |=> !o_wb_ack)
		else begin
			$error("wishbone ack high on two consecutive cycles");
			fail_cnt++;
		end

endmodule

bind sensor_frontend_top sensor_frontend_sva #(
	.DAT_W (SENSOR_DAT_WIDTH)
) u_sva (
	.clk        (clk),
	.i_reset    (i_reset),
	.i_fval     (i_fval),
	.i_lval     (i_lval),
	.o_fval     (o_fval),
	.o_lval     (o_lval),
	.o_pix_data (o_pix_data),
	.o_wb_ack   (o_wb_ack)
);

`default_nettype wire

//--- dv/sensor_frontend_tb.sv
// testbench for the sensor front end
// drives frames and wishbone accesses, checks the stream against a reference model
`timescale 1ns/1ps
`default_nettype none

module sensor_frontend_tb;

	localparam int DW  = 10;
	localparam int NPH = 5;
	// per phase: pattern, frames, lines, pixels per line
	// last phase uses an unassigned code, expected to pass through
	localparam logic [2:0] PH_MODE [NPH] = '{video_pkg::PAT_REAL, video_pkg::PAT_GRAY,
		video_pkg::PAT_SLANT, video_pkg::PAT_MOVE, 3'b101};
	localparam int PH_FRAMES [NPH] = '{2, 3, 2, 3, 1};
	localparam int PH_LINES  [NPH] = '{4, 3, 6, 4, 2};
	// 300 pixels wraps the 8-bit ramp
	localparam int PH_PIX    [NPH] = '{16, 8, 10, 300, 5};

	logic           clk = 1'b0;
	logic           i_reset;
	logic           i_wb_cyc;
	logic           i_wb_stb;
	logic           i_wb_we;
	logic [1:0]     i_wb_adr;
	logic [31:0]    i_wb_dat;
	wire  [31:0]    o_wb_dat;
	wire            o_wb_ack;
	logic           i_fval;
	logic           i_lval;
	logic [DW-1:0]  i_pix_data;
	wire            o_fval;
	wire            o_lval;
	wire  [DW-1:0]  o_pix_data;

	logic [31:0]    rng_state;
	logic [2:0]     cur_mode;
	int             frames_sent;
	int             stream_errors;
	int             reg_errors;
	// reference model state, indices since the last mode change
	logic [2:0]     model_mode;
	logic           prev_fval;
	logic           prev_act;
	int             frm;
	int             line;
	int             col;
	logic           exp_valid = 1'b0;
	logic           exp_fval;
	logic           exp_lval;
	logic [DW-1:0]  exp_pix;

	always #5 clk = ~clk;

	sensor_frontend_top #(
		.SENSOR_DAT_WIDTH (DW)
	) dut (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_wb_cyc   (i_wb_cyc),
		.i_wb_stb   (i_wb_stb),
		.i_wb_we    (i_wb_we),
		.i_wb_adr   (i_wb_adr),
		.i_wb_dat   (i_wb_dat),
		.o_wb_dat   (o_wb_dat),
		.o_wb_ack   (o_wb_ack),
		.i_fval     (i_fval),
		.i_lval     (i_lval),
		.i_pix_data (i_pix_data),
		.o_fval     (o_fval),
		.o_lval     (o_lval),
		.o_pix_data (o_pix_data)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// pattern byte in the top bits, zeros below
	function automatic logic [DW-1:0] pat_word(input logic [7:0] b);
		logic [DW-1:0] w;
		w = '0;
		w[DW-1 -: 8] = b;
		return w;
	endfunction

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	// fresh random data every cycle, blanking too
	task automatic drive_stream(input logic fval, input logic lval);
		@(negedge clk);
		rng_state = lcg_next(rng_state);
		i_fval = fval;
		i_lval = lval;
		i_pix_data = rng_state[31 -: DW];
	endtask

	// vblank, then lines with 3 cycles of hblank each, then fval low
	task automatic send_frame(input int lines, input int pixels);
		repeat (4) drive_stream(1'b0, 1'b0);
		for (int k = 0; k < lines; k++) begin
			repeat (pixels) drive_stream(1'b1, 1'b1);
			repeat (3) drive_stream(1'b1, 1'b0);
		end
		drive_stream(1'b0, 1'b0);
		frames_sent++;
	endtask

	// one classic cycle, ack expected on the next clock
	// hold leaves cyc and stb up into the cycle after ack,
	// like a master that starts its next access right away
	task automatic wb_access(input logic we, input logic [1:0] adr,
		input logic [31:0] wdat, input logic hold, output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(negedge clk);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = we;
		i_wb_adr = adr;
		i_wb_dat = wdat;
		do begin
			@(negedge clk);
			waited++;
		end while (!o_wb_ack && waited < 8);
		rdat = o_wb_dat;
		if (!hold) begin
			i_wb_cyc = 1'b0;
			i_wb_stb = 1'b0;
			i_wb_we  = 1'b0;
		end
		if (!o_wb_ack) begin
			$display("no wishbone ack for address %0d within 8 cycles at %0t", adr, $time);
			reg_errors++;
		end else begin
			assert (waited == 1) else begin
				$display("MISMATCH at %0t: ack after %0d cycles, expected 1", $time, waited);
				reg_errors++;
			end
		end
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
		logic [31:0] ignored;
		wb_access(1'b1, adr, data, 1'b0, ignored);
	endtask

	task automatic check_reg(input logic [1:0] adr, input logic [31:0] expected);
		logic [31:0] data;
		wb_access(1'b0, adr, 32'd0, 1'b0, data);
		assert (data === expected) else begin
			$display("MISMATCH at %0t: register %0d read %0h, expected %0h",
				$time, adr, data, expected);
			reg_errors++;
		end
	endtask

	// two reads with stb still high in the cycle after the first ack
	// the slave must skip that cycle and ack only the second request
	task automatic check_back_to_back(input logic [1:0] adr_a, input logic [31:0] exp_a,
		input logic [1:0] adr_b, input logic [31:0] exp_b);
		logic [31:0] data_a;
		logic [31:0] data_b;
		wb_access(1'b0, adr_a, 32'd0, 1'b1, data_a);
		wb_access(1'b0, adr_b, 32'd0, 1'b0, data_b);
		assert (data_a === exp_a && data_b === exp_b) else begin
			$display("MISMATCH at %0t: back to back reads %0h,%0h, expected %0h,%0h",
				$time, data_a, data_b, exp_a, exp_b);
			reg_errors++;
		end
	endtask

	// --------------------------------------------------
	// reference model, inputs as seen on the rising edge
	// --------------------------------------------------
	always @(posedge clk) begin : model
		logic act;
		act = i_fval & i_lval;
		exp_valid = 1'b1;
		if (i_reset) begin
			model_mode = video_pkg::PAT_REAL;
			exp_fval = 1'b0;
			exp_lval = 1'b0;
			exp_pix  = '0;
			prev_fval = 1'b0;
			prev_act = 1'b0;
			frm = 0;
			line = 0;
			col = 0;
		end else begin
			// new pattern restarts the frame index
			if (cur_mode != model_mode) begin
				model_mode = cur_mode;
				frm = 0;
			end
			exp_fval = i_fval;
			exp_lval = act;
			exp_pix  = '0;
			if (act) begin
				case (model_mode)
					// grey follows passthrough only, so it starts from the reset level 0
					video_pkg::PAT_GRAY:  exp_pix = pat_word(8'(frm));
					video_pkg::PAT_SLANT: exp_pix = pat_word(8'(line + col));
					video_pkg::PAT_MOVE:  exp_pix = pat_word(8'(frm + line + col));
					default:              exp_pix = i_pix_data;
				endcase
				col++;
			end else if (prev_act) begin
				line++;
				col = 0;
			end
			if (prev_fval && !i_fval) begin
				frm++;
				line = 0;
			end
			prev_fval = i_fval;
			prev_act  = act;
		end
	end

	// outputs compared mid cycle, well away from both edges
	always @(negedge clk) begin : compare
		if (exp_valid) begin
			assert (o_fval === exp_fval && o_lval === exp_lval) else begin
				$display("MISMATCH at %0t: fval,lval out %b,%b expected %b,%b",
					$time, o_fval, o_lval, exp_fval, exp_lval);
				stream_errors++;
			end
			assert (o_pix_data === exp_pix) else begin
				$display("MISMATCH at %0t: pixel out %0h, expected %0h",
					$time, o_pix_data, exp_pix);
				stream_errors++;
			end
		end
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin : stimulus
		int total;
		i_reset = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		i_fval = 1'b0;
		i_lval = 1'b0;
		i_pix_data = '0;
		rng_state = 32'd27;
		cur_mode = video_pkg::PAT_REAL;
		frames_sent = 0;
		stream_errors = 0;
		reg_errors = 0;
		repeat (16) @(negedge clk);
		i_reset = 1'b0;

		// reset values, readback, read-only write dropped
		check_reg(video_pkg::REG_PATTERN, 32'(video_pkg::PAT_REAL));
		check_reg(video_pkg::REG_FRAMES, 32'd0);
		wb_write(video_pkg::REG_PATTERN, 32'h5);
		check_reg(video_pkg::REG_PATTERN, 32'h5);
		wb_write(video_pkg::REG_FRAMES, 32'hffff);
		check_reg(video_pkg::REG_FRAMES, 32'd0);
		check_back_to_back(video_pkg::REG_PATTERN, 32'h5, video_pkg::REG_FRAMES, 32'd0);

		// mode changes only while fval is low
		for (int p = 0; p < NPH; p++) begin
			wb_write(video_pkg::REG_PATTERN, {29'd0, PH_MODE[p]});
			cur_mode = PH_MODE[p];
			check_reg(video_pkg::REG_PATTERN, {29'd0, PH_MODE[p]});
			for (int f = 0; f < PH_FRAMES[p]; f++) begin
				send_frame(PH_LINES[p], PH_PIX[p]);
				// geometry latches the cycle after output fval falls
				repeat (2) @(negedge clk);
				check_reg(video_pkg::REG_LINES, PH_LINES[p]);
				check_reg(video_pkg::REG_PIXELS, PH_PIX[p]);
				check_reg(video_pkg::REG_FRAMES, frames_sent);
			end
		end

		repeat (4) @(negedge clk);
		total = stream_errors + reg_errors + int'(dut.u_sva.fail_cnt);
		$display("errors: stream %0d, register %0d, assertion %0d",
			stream_errors, reg_errors, dut.u_sva.fail_cnt);
		if (total == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// budget is setup plus every frame with its readback, plus slack
	initial begin : watchdog
		int budget;
		budget = 300;
		for (int i = 0; i < NPH; i++) begin
			budget += PH_FRAMES[i] * (5 + PH_LINES[i] * (PH_PIX[i] + 3) + 40);
		end
		budget += 500;
		repeat (budget) @(posedge clk);
		$display("timeout: the run did not finish within %0d clock cycles", budget);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
verilog/video_pkg.sv
verilog/pattern_regs.sv
verilog/test_pattern.sv
verilog/frame_geometry.sv
verilog/sensor_frontend_top.sv
dv/sensor_frontend_sva.sv
dv/sensor_frontend_tb.sv

//--- Makefile
# Verilator flow for the sensor front end
TOP := sensor_frontend_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

# RTL top level with its bound checks, all warnings on
lint:
	verilator --lint-only -Wall --timing --top-module sensor_frontend_top -f build.f

# build and run, then pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -o $(TOP) -f build.f
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
